/* design/axi_perf_cfg.svh */
`ifndef AXI_PERF_CFG_SVH
`define AXI_PERF_CFG_SVH

// ====================
// SRAM geometry
// ====================

// Word address bits, kept small for simulation
`define SRAM_ADDR_WIDTH 10

// One SRAM word is one AXI beat
`define SRAM_DATA_WIDTH 16

// ====================
// Statistics
// ====================

`define STAT_WIDTH 32

`endif

/* design/axi_bus_pkg.sv */
`include "axi_perf_cfg.svh"

package axi_bus_pkg;

  // ====================
  // AXI write channel fields
  // ====================

  // Byte address, one bit wider than the SRAM word address
  typedef logic [`SRAM_ADDR_WIDTH:0] axi_addr_t;

  typedef logic [`SRAM_DATA_WIDTH-1:0] axi_data_t;

  typedef logic [`SRAM_DATA_WIDTH/8-1:0] axi_strb_t;

  // Beats in a burst minus one
  typedef logic [7:0] axi_len_t;

  typedef logic [1:0] axi_resp_t;

  // Write response codes
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

/* design/perf_pkg.sv */
`include "axi_perf_cfg.svh"

package perf_pkg;

  // SRAM pins
  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;

  // Run statistics and settings
  typedef logic [`STAT_WIDTH-1:0] stat_t;
  typedef logic [7:0] burst_cnt_t;

  // ====================
  // State machines
  // ====================

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } writer_state_t;

  typedef enum logic [1:0] {
    CT_IDLE,
    CT_SETUP,
    CT_STROBE,
    CT_RESP
  } ctrl_state_t;

endpackage

/* design/axi_perf_writer.sv */
`timescale 1ns/1ns

module axi_perf_writer
  import axi_bus_pkg::*;
  import perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       start,
  input  sram_addr_t base_word,
  input  axi_len_t   burst_len,
  input  burst_cnt_t burst_count,
  input  sram_data_t data_seed,
  output logic       busy,
  output logic       done,

  output logic       awvalid,
  input  logic       awready,
  output axi_addr_t  awaddr,
  output axi_len_t   awlen,
  output logic       wvalid,
  input  logic       wready,
  output axi_data_t  wdata,
  output axi_strb_t  wstrb,
  output logic       wlast,
  input  logic       bvalid,
  output logic       bready,
  input  axi_resp_t  bresp
);

  writer_state_t state;
  axi_len_t      beat_q;
  burst_cnt_t    left_q;
  logic          done_q;
  logic          bready_q;

  sram_addr_t    word_q;
  axi_len_t      len_q;
  sram_data_t    seed_q;

  logic          last_beat;

  assign last_beat = beat_q == len_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= WR_IDLE;
      beat_q   <= '0;
      left_q   <= '0;
      done_q   <= 1'b0;
      bready_q <= 1'b0;
    end else begin
      done_q   <= 1'b0;
      // B is taken one cycle after it shows up
      bready_q <= (state == WR_RESP) && bvalid && !bready_q;
      case (state)
        WR_IDLE: begin
          if (start) begin
            left_q <= burst_count;
            state  <= WR_ADDR;
          end
        end
        WR_ADDR: begin
          if (awready) begin
            beat_q <= '0;
            state  <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (wready) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (bvalid && bready_q) begin
            left_q <= left_q - 1'b1;
            if (left_q == burst_cnt_t'(1)) begin
              state  <= WR_IDLE;
              done_q <= 1'b1;
            end else begin
              state <= WR_ADDR;
            end
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Run settings, word index walks across bursts and wraps at the top
  always_ff @(posedge clk) begin
    if (state == WR_IDLE && start) begin
      word_q <= base_word;
      len_q  <= burst_len;
      seed_q <= data_seed;
    end else if (state == WR_DATA && wready) begin
      word_q <= word_q + 1'b1;
    end
  end

  assign busy    = state != WR_IDLE;
  assign done    = done_q;
  assign awvalid = state == WR_ADDR;
  assign awaddr  = {word_q, 1'b0};
  assign awlen   = len_q;
  assign wvalid  = state == WR_DATA;
  assign wdata   = sram_data_t'(word_q) ^ seed_q;
  assign wstrb   = '1;
  assign wlast   = last_beat;
  assign bready  = bready_q;

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

  b_okay: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && bready |-> bresp == AXI_RESP_OKAY);

endmodule

/* design/axi_sram_wr_ctrl.sv */
`timescale 1ns/1ns

module axi_sram_wr_ctrl
  import axi_bus_pkg::*;
  import perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       awvalid,
  output logic       awready,
  input  axi_addr_t  awaddr,
  input  axi_len_t   awlen,
  input  logic       wvalid,
  output logic       wready,
  input  axi_data_t  wdata,
  input  axi_strb_t  wstrb,
  input  logic       wlast,
  output logic       bvalid,
  input  logic       bready,
  output axi_resp_t  bresp,

  output sram_addr_t sram_addr,
  output sram_data_t sram_data,
  output logic       sram_we_n,
  output logic       sram_ce_n
);

  ctrl_state_t state;
  axi_len_t    beat_q;
  logic        we_half_q;

  sram_addr_t  addr_q;
  axi_len_t    len_q;

  logic        last_beat;

  assign last_beat = beat_q == len_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= CT_IDLE;
      beat_q <= '0;
    end else begin
      case (state)
        CT_IDLE: begin
          if (awvalid) begin
            beat_q <= '0;
            state  <= CT_SETUP;
          end
        end
        CT_SETUP: begin
          if (wvalid) state <= CT_STROBE;
        end
        CT_STROBE: begin
          beat_q <= beat_q + 1'b1;
          state  <= last_beat ? CT_RESP : CT_SETUP;
        end
        CT_RESP: begin
          if (bready) state <= CT_IDLE;
        end
        default: state <= CT_IDLE;
      endcase
    end
  end

  // Word address from the byte address, then one word per beat
  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      addr_q <= sram_addr_t'(awaddr >> 1);
      len_q  <= awlen;
    end else if (state == CT_STROBE) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // we_n rises mid strobe so address and data hold past the rising edge
  always_ff @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_half_q <= 1'b0;
    end else begin
      we_half_q <= state == CT_STROBE;
    end
  end

  assign awready = state == CT_IDLE;
  assign wready  = state == CT_STROBE;
  assign bvalid  = state == CT_RESP;
  assign bresp   = AXI_RESP_OKAY;

  assign sram_addr = addr_q;
  // No byte lanes on the part, partial beats are dropped
  assign sram_data = wdata;
  assign sram_we_n = !(state == CT_STROBE && !we_half_q && (&wstrb));
  assign sram_ce_n = !(state == CT_SETUP || state == CT_STROBE);

  wlast_match: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> wlast == last_beat);

  // Strobe is only seen low before the falling edge, on the setup address and data
  we_in_ce: assert property (@(negedge clk) disable iff (!rst_n)
    !sram_we_n |-> !sram_ce_n && $stable(sram_addr) && $stable(sram_data));

endmodule

/* design/axi_perf_stats.sv */
`timescale 1ns/1ns

module axi_perf_stats
  import perf_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  logic  done,
  input  logic  w_fire,
  input  logic  b_fire,
  output stat_t cycles,
  output stat_t beats,
  output stat_t bursts
);

  logic busy_q;
  logic accept;

  // Writer is idle again in the done cycle
  assign accept = start && (!busy_q || done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cycles <= '0;
      beats  <= '0;
      bursts <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cycles <= '0;
      beats  <= '0;
      bursts <= '0;
    end else begin
      if (done) busy_q <= 1'b0;
      if (busy_q) cycles <= cycles + 1'b1;
      if (w_fire) beats <= beats + 1'b1;
      if (b_fire) bursts <= bursts + 1'b1;
    end
  end

endmodule

/* design/axi_perf_sram_top.sv */
`timescale 1ns/1ns

module axi_perf_sram_top
  import axi_bus_pkg::*;
  import perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       start,
  input  sram_addr_t base_word,
  input  axi_len_t   burst_len,
  input  burst_cnt_t burst_count,
  input  sram_data_t data_seed,
  output logic       busy,
  output logic       done,
  output stat_t      cycles,
  output stat_t      beats,
  output stat_t      bursts,

  output sram_addr_t sram_addr,
  output sram_data_t sram_data,
  output logic       sram_we_n,
  output logic       sram_ce_n
);

  logic      awvalid;
  logic      awready;
  axi_addr_t awaddr;
  axi_len_t  awlen;
  logic      wvalid;
  logic      wready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast;
  logic      bvalid;
  logic      bready;
  axi_resp_t bresp;

  logic      w_fire;
  logic      b_fire;

  assign w_fire = wvalid & wready;
  assign b_fire = bvalid & bready;

  axi_perf_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .base_word  (base_word),
    .burst_len  (burst_len),
    .burst_count(burst_count),
    .data_seed  (data_seed),
    .busy       (busy),
    .done       (done),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp)
  );

  axi_sram_wr_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .awlen    (awlen),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wlast    (wlast),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_ce_n(sram_ce_n)
  );

  axi_perf_stats u_stats (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .done  (done),
    .w_fire(w_fire),
    .b_fire(b_fire),
    .cycles(cycles),
    .beats (beats),
    .bursts(bursts)
  );

endmodule

/* verification/sram_model.sv */
`timescale 1ns/1ns

module sram_model
  import perf_pkg::*;
(
  input sram_addr_t addr,
  input sram_data_t data,
  input logic       we_n,
  input logic       ce_n
);

  localparam int DEPTH = 1 << $bits(sram_addr_t);

  sram_data_t mem [DEPTH];

  // ====================
  // Storage
  // ====================

  // Power-up contents, a different word at every address
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[sram_addr_t'(a)] = sram_data_t'(a * 40503) ^ 16'h2b1d;
    end
  end

  // Word is taken when the write strobe rises with the chip selected
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] = data;
    end
  end

  // ====================
  // Backdoor read
  // ====================

  function automatic sram_data_t peek(input sram_addr_t a);
    return mem[a];
  endfunction

endmodule

/* verification/tb_axi_perf_sram.sv */
`timescale 1ns/1ns

module tb_axi_perf_sram
  import axi_bus_pkg::*;
  import perf_pkg::*;
();

  localparam int DEPTH    = 1 << $bits(sram_addr_t);
  localparam int NUM_RUNS = 5;

  logic       clk;
  logic       rst_n;
  logic       start;
  sram_addr_t base_word;
  axi_len_t   burst_len;
  burst_cnt_t burst_count;
  sram_data_t data_seed;
  logic       busy;
  logic       done;
  stat_t      cycles;
  stat_t      beats;
  stat_t      bursts;
  sram_addr_t sram_addr;
  sram_data_t sram_data;
  logic       sram_we_n;
  logic       sram_ce_n;

  // Run table, one row per test
  sram_addr_t run_base       [NUM_RUNS];
  axi_len_t   run_len        [NUM_RUNS];
  burst_cnt_t run_count      [NUM_RUNS];
  sram_data_t run_seed       [NUM_RUNS];
  logic       run_busy_start [NUM_RUNS];
  stat_t      run_beats      [NUM_RUNS];
  stat_t      run_min_cycles [NUM_RUNS];

  sram_data_t  exp_mem [DEPTH];
  logic [31:0] lfsr_state;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  int          cycle_limit;

  axi_perf_sram_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .base_word  (base_word),
    .burst_len  (burst_len),
    .burst_count(burst_count),
    .data_seed  (data_seed),
    .busy       (busy),
    .done       (done),
    .cycles     (cycles),
    .beats      (beats),
    .bursts     (bursts),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_model u_mem (
    .addr(sram_addr),
    .data(sram_data),
    .we_n(sram_we_n),
    .ce_n(sram_ce_n)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic add_run(input int r, input sram_addr_t base, input axi_len_t len,
                         input burst_cnt_t count, input logic busy_start);
    logic [31:0] bits;
    take_bits(16, bits);
    run_base[r]       = base;
    run_len[r]        = len;
    run_count[r]      = count;
    run_seed[r]       = bits[15:0];
    run_busy_start[r] = busy_start;
    run_beats[r]      = stat_t'(count) * (stat_t'(len) + 1);
    run_min_cycles[r] = stat_t'(count) * (2 * (stat_t'(len) + 1) + 3);
    cycle_limit       = cycle_limit + 4 * (int'(len) + 1) * int'(count) + 20;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic run_row(input int r);
    int w;
    $display("Run %0d: base 0x%0h len %0d count %0d seed 0x%0h", r, run_base[r],
             run_len[r], run_count[r], run_seed[r]);
    @(posedge clk);
    #1;
    base_word   = run_base[r];
    burst_len   = run_len[r];
    burst_count = run_count[r];
    data_seed   = run_seed[r];
    start       = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (run_busy_start[r]) begin
      repeat (3) @(posedge clk);
      #1;
      compare("busy before second start", 32'(busy), 32'd1);
      // Different settings that must never reach the SRAM
      base_word = run_base[r] + sram_addr_t'(DEPTH / 2);
      burst_len = run_len[r] + 8'd1;
      data_seed = ~run_seed[r];
      start     = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    compare("beats", beats, run_beats[r]);
    compare("bursts", bursts, stat_t'(run_count[r]));
    compare($sformatf("cycles %0d at least %0d", cycles, run_min_cycles[r]),
            32'(cycles >= run_min_cycles[r]), 32'd1);
    for (int j = 0; j < int'(run_count[r]); j++) begin
      for (int k = 0; k <= int'(run_len[r]); k++) begin
        w = (int'(run_base[r]) + j * (int'(run_len[r]) + 1) + k) % DEPTH;
        exp_mem[sram_addr_t'(w)] = sram_data_t'(w) ^ run_seed[r];
      end
    end
    for (int a = 0; a < DEPTH; a++) begin
      compare($sformatf("word 0x%03h", a), 32'(u_mem.peek(sram_addr_t'(a))),
              32'(exp_mem[sram_addr_t'(a)]));
    end
    report_test($sformatf("run %0d", r));
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    base_word    = '0;
    burst_len    = '0;
    burst_count  = '0;
    data_seed    = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    lfsr_state   = 32'h797af32b;

    add_run(0, 10'h010, 8'd3, 8'd4, 1'b0);
    // Walks past the top word and wraps to zero
    add_run(1, 10'h3f0, 8'd7, 8'd4, 1'b0);
    add_run(2, 10'h100, 8'd0, 8'd5, 1'b0);
    add_run(3, 10'h200, 8'd15, 8'd3, 1'b0);
    add_run(4, 10'h080, 8'd1, 8'd6, 1'b1);

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare("busy after reset", 32'(busy), 32'd0);
    compare("done after reset", 32'(done), 32'd0);
    compare("sram_we_n after reset", 32'(sram_we_n), 32'd1);
    compare("sram_ce_n after reset", 32'(sram_ce_n), 32'd1);
    report_test("reset values");

    for (int a = 0; a < DEPTH; a++) begin
      exp_mem[sram_addr_t'(a)] = u_mem.peek(sram_addr_t'(a));
    end

    for (int r = 0; r < NUM_RUNS; r++) begin
      run_row(r);
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/axi_bus_pkg.sv
design/perf_pkg.sv
design/axi_perf_writer.sv
design/axi_sram_wr_ctrl.sv
design/axi_perf_stats.sv
design/axi_perf_sram_top.sv
verification/sram_model.sv
verification/tb_axi_perf_sram.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the simulation log for the failure line
verilator --binary --timing --assert --timescale 1ns/1ns -f flist.f \
  --top-module tb_axi_perf_sram -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Test run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No final result in log"; exit 1; }
exit 0
